// ==== Makefile ====
# verilator build of the ooo core testbench, run decided by the log

SIM := obj_dir/Vooo_core_tb

$(SIM): ooo_core.f ooo_core_config.svh $(filter %.sv,$(shell cat ooo_core.f))
	verilator --binary --assert --timescale 1ns/1ps -j 0 -f ooo_core.f \
		--top-module ooo_core_tb -o Vooo_core_tb

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== arch_regfile.sv ====
/*
 * committed register state, written at retire
 */
`include "ooo_core_config.svh"

module arch_regfile
    import isa_pkg::*, rob_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  retire_t          retire,
    input  reg_idx_t         read_reg,
    output logic [`XLEN-1:0] read_value
);

    logic [`XLEN-1:0] regs [`ARCH_REGS];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.opcode == op_alu && retire.dest != '0) begin
            // r0 stays zero
            regs[retire.dest] <= retire.value;
        end
    end

    // dispatch source read, no bypass needed
    assign read_value = regs[read_reg];

endmodule

// ==== completion_timer.sv ====
/*
 * per-tag completion slots: operand wait, latency countdown,
 * result and branch outcome, single cdb arbitration
 */
`include "ooo_core_config.svh"

module completion_timer
    import isa_pkg::*, rob_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    input  rob_tag_t  tail_tag,
    input  operand_t  operand,
    input  logic      flush,
    output cdb_t      cdb
);

    typedef struct packed {
        logic              valid;
        opcode_t           opcode;
        instr_u            instr;
        logic              op_ready;
        logic [`XLEN-1:0]  op_value;
        rob_tag_t          op_tag;
        logic [`LAT_W-1:0] lat;
    } slot_t;

    // slot index equals rob tag
    slot_t              slots [`ROB_SZ];
    logic [`ROB_SZ-1:0] req;
    rob_tag_t           win;
    slot_t              win_slot;

    ////////////////////
    // arbitration
    ////////////////////

    // done counting with the operand in hand
    always_comb begin
        for (int i = 0; i < `ROB_SZ; i++) begin
            req[i] = slots[i].valid && slots[i].op_ready && slots[i].lat == '0;
        end
    end

    // lowest index wins, scan from the top
    always_comb begin
        win = '0;
        for (int i = `ROB_SZ - 1; i >= 0; i--) begin
            if (req[i]) begin
                win = rob_tag_t'(i);
            end
        end
    end

    assign win_slot = slots[win];

    // result from the view that matches the opcode
    always_comb begin
        cdb.valid      = |req;
        cdb.tag        = win;
        cdb.value      = '0;
        cdb.mispredict = 1'b0;
        if (win_slot.opcode == op_alu) begin
            cdb.value = win_slot.op_value + win_slot.instr.alu.imm;
        end else begin
            // taken when the source is zero
            cdb.mispredict = (win_slot.op_value == '0) != win_slot.instr.branch.pred_taken;
        end
    end

    ////////////////////
    // slot update
    ////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `ROB_SZ; i++) begin
                slots[i] <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < `ROB_SZ; i++) begin
                slots[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `ROB_SZ; i++) begin
                // snoop the broadcast for a waiting operand
                if (slots[i].valid && !slots[i].op_ready
                        && cdb.valid && cdb.tag == slots[i].op_tag) begin
                    slots[i].op_ready <= 1'b1;
                    slots[i].op_value <= cdb.value;
                end
                // count only once the operand is there
                if (slots[i].valid && slots[i].op_ready && slots[i].lat != '0) begin
                    slots[i].lat <= slots[i].lat - 1'b1;
                end
            end
            // winner leaves, losers hold their request
            if (cdb.valid) begin
                slots[win].valid <= 1'b0;
            end
            if (dispatch_valid) begin
                slots[tail_tag].valid    <= 1'b1;
                slots[tail_tag].opcode   <= dispatch.opcode;
                slots[tail_tag].instr    <= dispatch.instr;
                slots[tail_tag].op_ready <= operand.ready;
                slots[tail_tag].op_value <= operand.value;
                slots[tail_tag].op_tag   <= operand.tag;
                slots[tail_tag].lat      <= dispatch.instr.alu.lat;
            end
        end
    end

endmodule

// ==== isa_pkg.sv ====
/*
 * instruction set types: register index, opcode and the
 * instruction payload union with alu and branch views
 */
`include "ooo_core_config.svh"

package isa_pkg;

    typedef logic [$clog2(`ARCH_REGS)-1:0] reg_idx_t;

    typedef enum logic {
        op_alu,
        op_branch
    } opcode_t;

    ////////////////////
    // payload views
    ////////////////////

    // src and lat sit at the same bits in both views
    typedef struct packed {
        reg_idx_t          src;
        logic [`LAT_W-1:0] lat;
        reg_idx_t          dest;
        logic [`XLEN-1:0]  imm;
        logic [1:0]        pad;
    } alu_fmt_t;

    // pad sized so both views stay 27 bits wide
    typedef struct packed {
        reg_idx_t               src;
        logic [`LAT_W-1:0]      lat;
        logic                   pred_taken;
        logic [`XLEN-1:0]       target;
        logic [$bits(reg_idx_t):0] pad;
    } branch_fmt_t;

    // one payload word, decoded per opcode
    typedef union packed {
        alu_fmt_t    alu;
        branch_fmt_t branch;
    } instr_u;

endpackage

// ==== map_table.sv ====
/*
 * rename table from architectural register to rob tag
 */
`include "ooo_core_config.svh"

module map_table
    import isa_pkg::*, rob_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       dispatch_valid,
    input  dispatch_t  dispatch,
    input  rob_tag_t   tail_tag,
    input  retire_t    retire,
    input  logic       flush,
    output map_entry_t src_map
);

    map_entry_t map_q [`ARCH_REGS];
    reg_idx_t   dest_reg;
    logic       rename;

    assign dest_reg = dispatch.instr.alu.dest;

    // alu writers only, r0 is never renamed
    assign rename = dispatch_valid && dispatch.opcode == op_alu && dest_reg != '0;

    // src sits at the same bits for both forms
    assign src_map = map_q[dispatch.instr.alu.src];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= '0;
            end
        end else if (flush) begin
            // committed state is all that is left
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= '0;
            end
        end else begin
            // a newer rename keeps the register busy
            if (retire.valid && retire.opcode == op_alu
                    && map_q[retire.dest].tag == retire.tag) begin
                map_q[retire.dest].busy <= 1'b0;
            end
            // same-cycle dispatch wins over the retire clear
            if (rename) begin
                map_q[dest_reg].busy <= 1'b1;
                map_q[dest_reg].tag  <= tail_tag;
            end
        end
    end

endmodule

// ==== ooo_core.f ====
+incdir+.
isa_pkg.sv
rob_pkg.sv
rob.sv
map_table.sv
completion_timer.sv
recovery_fsm.sv
arch_regfile.sv
ooo_core.sv
ooo_core_props.sv
ooo_core_tb.sv

// ==== ooo_core.sv ====
/*
 * top level of the out-of-order back end
 */
`include "ooo_core_config.svh"

module ooo_core
    import rob_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  dispatch_t        dispatch,
    output logic             dispatch_ready,
    output retire_t          retire,
    output logic             redirect,
    output logic [`XLEN-1:0] redirect_target
);

    logic             dispatch_fire;
    logic             rob_full;
    logic             dispatch_hold;
    logic             flush;
    rob_tag_t         tail_tag;
    operand_t         operand;
    map_entry_t       src_map;
    cdb_t             cdb;
    logic [`XLEN-1:0] src_reg_value;

    // stall on a full rob or during recovery
    assign dispatch_ready = !rob_full && !dispatch_hold;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    rob u_rob (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_fire),
        .dispatch       (dispatch),
        .src_map        (src_map),
        .src_reg_value  (src_reg_value),
        .cdb            (cdb),
        .flush          (flush),
        .rob_full       (rob_full),
        .tail_tag       (tail_tag),
        .operand        (operand),
        .retire         (retire)
    );

    map_table u_map_table (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_fire),
        .dispatch       (dispatch),
        .tail_tag       (tail_tag),
        .retire         (retire),
        .flush          (flush),
        .src_map        (src_map)
    );

    completion_timer u_completion_timer (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_fire),
        .dispatch       (dispatch),
        .tail_tag       (tail_tag),
        .operand        (operand),
        .flush          (flush),
        .cdb            (cdb)
    );

    recovery_fsm u_recovery_fsm (
        .clock           (clock),
        .reset           (reset),
        .retire          (retire),
        .flush           (flush),
        .dispatch_hold   (dispatch_hold),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    // source field is shared by both instruction forms
    arch_regfile u_arch_regfile (
        .clock      (clock),
        .reset      (reset),
        .retire     (retire),
        .read_reg   (dispatch.instr.alu.src),
        .read_value (src_reg_value)
    );

endmodule

// ==== ooo_core_config.svh ====
/*
 * sizing defines for the ooo core: rob depth, register count,
 * data width and latency counter width
 */
`ifndef OOO_CORE_CONFIG_SVH
`define OOO_CORE_CONFIG_SVH

// reorder buffer depth, also the number of timer slots
`define ROB_SZ 8
// architectural registers, r0 reads as zero
`define ARCH_REGS 8
// data path width
`define XLEN 16
// width of the encoded completion latency
`define LAT_W 3

`endif

// ==== ooo_core_props.sv ====
/*
 * bound checks on the core: reset state, full stall, recovery timing
 */
`include "ooo_core_config.svh"

module ooo_core_props
    import isa_pkg::*, rob_pkg::*;
(
    input logic             clock,
    input logic             reset,
    input logic             dispatch_valid,
    input logic             dispatch_ready,
    input logic             rob_full,
    input logic             flush,
    input cdb_t             cdb,
    input retire_t          retire,
    input logic             redirect,
    input logic [`XLEN-1:0] redirect_target
);

    timeunit 1ns;
    timeprecision 100ps;

    int   fail_count = 0;
    // accepted and not yet retired, counted at the ports
    int   inflight;
    logic accepted;
    logic bad_retire;

    assign accepted   = dispatch_valid && dispatch_ready;
    assign bad_retire = retire.valid && retire.opcode == op_branch && retire.mispredict;

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            inflight <= 0;
        end else if (flush) begin
            inflight <= 0;
        end else begin
            inflight <= inflight + (accepted ? 1 : 0) - (retire.valid ? 1 : 0);
        end
    end

    // first edge out of reset, everything idle
    a_reset_state: assert property (@(posedge clock)
        $fell(reset) |-> dispatch_ready && !rob_full && !retire.valid && !redirect
            && !flush && !cdb.valid)
        else begin
            fail_count++;
            $error("core not idle after reset");
        end

    ////////////////////
    // back-pressure
    ////////////////////

    // ready only while an entry is free
    a_full_stall: assert property (@(posedge clock) disable iff (reset)
        !(flush || redirect) |-> dispatch_ready == (inflight < `ROB_SZ))
        else begin
            fail_count++;
            $error("dispatch ready does not follow the number of instructions in flight");
        end

    ////////////////////
    // recovery
    ////////////////////

    // flush one edge after the bad branch, redirect one edge later
    a_flush_timing: assert property (@(posedge clock) disable iff (reset)
        flush == $past(bad_retire))
        else begin
            fail_count++;
            $error("flush not one cycle after a bad branch");
        end

    a_redirect_timing: assert property (@(posedge clock) disable iff (reset)
        redirect == $past(bad_retire, 2))
        else begin
            fail_count++;
            $error("redirect not two cycles after a bad branch");
        end

    a_redirect_target: assert property (@(posedge clock) disable iff (reset)
        redirect |-> redirect_target == $past(retire.target, 2))
        else begin
            fail_count++;
            $error("redirect target differs from the branch");
        end

    a_hold: assert property (@(posedge clock) disable iff (reset)
        (flush || redirect) |-> !dispatch_ready)
        else begin
            fail_count++;
            $error("dispatch ready during recovery");
        end

    // flush leaves nothing in flight
    a_quiet_flush: assert property (@(posedge clock) disable iff (reset)
        flush |=> !retire.valid && !cdb.valid)
        else begin
            fail_count++;
            $error("work still in flight after a flush");
        end

endmodule

// ==== ooo_core_tb.sv ====
/*
 * testbench for the ooo core: lfsr program generator,
 * in-order golden model, retire checks and report
 */
`include "ooo_core_config.svh"

module ooo_core_tb
    import isa_pkg::*, rob_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_LAT     = (1 << `LAT_W) - 1;
    localparam int N_INSTR     = 160;
    localparam int CYCLE_LIMIT = N_INSTR * (MAX_LAT + `ROB_SZ) + 500;

    // what the model expects at retire
    typedef struct packed {
        opcode_t          opcode;
        reg_idx_t         dest;
        rob_tag_t         tag;
        logic [`XLEN-1:0] value;
        logic             mispredict;
        logic [`XLEN-1:0] target;
    } expected_t;

    logic             clock = 1'b0;
    logic             reset;
    logic             dispatch_valid;
    dispatch_t        dispatch;
    logic             dispatch_ready;
    retire_t          retire;
    logic             redirect;
    logic [`XLEN-1:0] redirect_target;

    expected_t        expected_q [$];
    expected_t        expected_front;
    logic             expected_valid;
    // wrong path after a mispredict, until redirect
    logic             discarding;
    // rob slots go out in order, back to zero after recovery
    rob_tag_t         next_tag;
    logic [`XLEN-1:0] model_regs [`ARCH_REGS];
    logic [31:0]      lfsr = 32'hfb2aceba;
    int               error_count = 0;
    int               errors_before = 0;
    int               tests_run = 0;
    int               cycles = 0;
    string            test_name = "reset_state";

    always #5 clock = ~clock;

    ooo_core uut (
        .clock           (clock),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .dispatch        (dispatch),
        .dispatch_ready  (dispatch_ready),
        .retire          (retire),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    bind ooo_core ooo_core_props props (
        .clock           (clock),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .dispatch_ready  (dispatch_ready),
        .rob_full        (rob_full),
        .flush           (flush),
        .cdb             (cdb),
        .retire          (retire),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    ////////////////////
    // stimulus helpers
    ////////////////////

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return bits;
    endfunction

    function automatic reg_idx_t random_reg();
        return reg_idx_t'(take_bits($bits(reg_idx_t)));
    endfunction

    function automatic dispatch_t make_alu(input reg_idx_t src, input logic [`LAT_W-1:0] lat);
        dispatch_t d;
        d = '0;
        d.opcode         = op_alu;
        d.instr.alu.src  = src;
        d.instr.alu.lat  = lat;
        d.instr.alu.dest = random_reg();
        d.instr.alu.imm  = `XLEN'(take_bits(`XLEN));
        return d;
    endfunction

    function automatic dispatch_t make_branch(input reg_idx_t src, input logic pred_taken);
        dispatch_t d;
        d = '0;
        d.opcode                  = op_branch;
        d.instr.branch.src        = src;
        d.instr.branch.pred_taken = pred_taken;
        d.instr.branch.target     = `XLEN'(take_bits(`XLEN));
        d.instr.branch.lat        = `LAT_W'(take_bits(`LAT_W));
        return d;
    endfunction

    function automatic int total_errors();
        return error_count + uut.props.fail_count;
    endfunction

    // hold the instruction until the core takes it
    task automatic issue(input dispatch_t d);
        logic taken;
        dispatch_valid = 1'b1;
        dispatch       = d;
        taken          = 1'b0;
        while (!taken) begin
            taken = dispatch_ready;
            @(negedge clock);
        end
        dispatch_valid = 1'b0;
    endtask

    // all accepted work retired and recovery over
    task automatic drain();
        while (expected_q.size() != 0 || discarding || !dispatch_ready) begin
            @(negedge clock);
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errors_before = total_errors();
    endtask

    task automatic end_test();
        int errs;
        errs = total_errors() - errors_before;
        tests_run++;
        $display("test %-14s %0s, %0d errors", test_name, errs == 0 ? "ok" : "failed", errs);
    endtask

    ////////////////////
    // golden model
    ////////////////////

    // executes each accepted instruction in program order
    always @(posedge clock or posedge reset) begin
        expected_t        e;
        logic [`XLEN-1:0] src_val;
        if (reset) begin
            expected_q.delete();
            for (int i = 0; i < `ARCH_REGS; i++) begin
                model_regs[i] = '0;
            end
            expected_front <= '0;
            expected_valid <= 1'b0;
            discarding     <= 1'b0;
            next_tag       <= '0;
        end else begin
            if (retire.valid && expected_q.size() != 0) begin
                void'(expected_q.pop_front());
            end
            // wrong-path instructions still take a slot
            if (dispatch_valid && dispatch_ready) begin
                next_tag <= rob_tag_t'((int'(next_tag) + 1) % `ROB_SZ);
            end
            if (dispatch_valid && dispatch_ready && !discarding) begin
                src_val  = model_regs[dispatch.instr.alu.src];
                e        = '0;
                e.opcode = dispatch.opcode;
                e.tag    = next_tag;
                if (dispatch.opcode == op_alu) begin
                    e.dest  = dispatch.instr.alu.dest;
                    e.value = src_val + dispatch.instr.alu.imm;
                    if (e.dest != '0) begin
                        model_regs[e.dest] = e.value;
                    end
                end else begin
                    // taken when the source is zero
                    e.mispredict = (src_val == '0) != dispatch.instr.branch.pred_taken;
                    e.target     = dispatch.instr.branch.target;
                    if (e.mispredict) begin
                        discarding <= 1'b1;
                    end
                end
                expected_q.push_back(e);
            end
            if (redirect) begin
                discarding <= 1'b0;
                next_tag   <= '0;
            end
            expected_valid <= expected_q.size() != 0;
            expected_front <= (expected_q.size() != 0) ? expected_q[0] : '0;
        end
    end

    ////////////////////
    // retire checks
    ////////////////////

    a_retire_expected: assert property (@(posedge clock) disable iff (reset)
        retire.valid |-> expected_valid)
        else begin
            error_count++;
            $display("%s: an instruction retired that the model does not expect", test_name);
        end

    a_retire_opcode: assert property (@(posedge clock) disable iff (reset)
        retire.valid && expected_valid |-> retire.opcode == expected_front.opcode)
        else begin
            error_count++;
            $display("Error %s opcode: expected %0d, actual %0d", test_name,
                $sampled(expected_front.opcode), $sampled(retire.opcode));
        end

    // rob slot of the retiring instruction
    a_retire_tag: assert property (@(posedge clock) disable iff (reset)
        retire.valid && expected_valid |-> retire.tag == expected_front.tag)
        else begin
            error_count++;
            $display("Error %s tag: expected %0d, actual %0d", test_name,
                $sampled(expected_front.tag), $sampled(retire.tag));
        end

    // alu result and destination
    a_retire_alu: assert property (@(posedge clock) disable iff (reset)
        retire.valid && expected_valid && expected_front.opcode == op_alu
            |-> retire.dest == expected_front.dest && retire.value == expected_front.value)
        else begin
            error_count++;
            $display("Error %s alu: expected r%0d=%h, actual r%0d=%h", test_name,
                $sampled(expected_front.dest), $sampled(expected_front.value),
                $sampled(retire.dest), $sampled(retire.value));
        end

    a_retire_branch: assert property (@(posedge clock) disable iff (reset)
        retire.valid && expected_valid && expected_front.opcode == op_branch
            |-> retire.mispredict == expected_front.mispredict
                && retire.target == expected_front.target)
        else begin
            error_count++;
            $display("Error %s branch: expected %0d/%h, actual %0d/%h", test_name,
                $sampled(expected_front.mispredict), $sampled(expected_front.target),
                $sampled(retire.mispredict), $sampled(retire.target));
        end

    // hang guard sized from the instruction count
    always @(posedge clock) begin
        cycles++;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout in %s after %0d cycles", test_name, cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        reg_idx_t src;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        start_test("reset_state");
        repeat (3) @(negedge clock);
        end_test();

        start_test("independent");
        repeat (24) issue(make_alu('0, `LAT_W'(take_bits(`LAT_W))));
        drain();
        end_test();

        // short latencies so producers often broadcast during dispatch
        start_test("dependent");
        repeat (48) issue(make_alu(random_reg(), `LAT_W'(take_bits(2))));
        drain();
        end_test();

        start_test("back_pressure");
        repeat (20) issue(make_alu(random_reg(), `LAT_W'(MAX_LAT)));
        drain();
        end_test();

        start_test("mispredict");
        repeat (3) begin
            issue(make_alu(random_reg(), `LAT_W'(take_bits(`LAT_W))));
            src = random_reg();
            // guess the opposite of the committed outcome
            issue(make_branch(src, model_regs[src] != '0));
            repeat (4) issue(make_alu(random_reg(), `LAT_W'(take_bits(`LAT_W))));
            drain();
            repeat (8) issue(make_alu(random_reg(), `LAT_W'(take_bits(`LAT_W))));
            drain();
        end
        end_test();

        start_test("correct_branch");
        repeat (24) begin
            src = random_reg();
            if (take_bits(1) != 0) begin
                issue(make_branch(src, model_regs[src] == '0));
            end else begin
                issue(make_alu(src, `LAT_W'(take_bits(`LAT_W))));
            end
        end
        drain();
        end_test();

        $display("tests %0d, errors %0d", tests_run, total_errors());
        if (total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== recovery_fsm.sv ====
/*
 * run, flush and resume sequencing after a mispredicted branch retires
 */
`include "ooo_core_config.svh"

module recovery_fsm
    import isa_pkg::*, rob_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  retire_t          retire,
    output logic             flush,
    output logic             dispatch_hold,
    output logic             redirect,
    output logic [`XLEN-1:0] redirect_target
);

    typedef enum logic [1:0] {
        st_run,
        st_flush,
        st_resume
    } state_t;

    state_t           state;
    state_t           state_next;
    logic [`XLEN-1:0] target_q;
    logic             bad_branch;

    assign bad_branch = retire.valid && retire.opcode == op_branch && retire.mispredict;

    // flush and resume each last one cycle
    always_comb begin
        case (state)
            st_run:    state_next = bad_branch ? st_flush : st_run;
            st_flush:  state_next = st_resume;
            default:   state_next = st_run;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_run;
        end else begin
            state <= state_next;
        end
    end

    // target of the retiring branch
    always_ff @(posedge clock) begin
        if (bad_branch) begin
            target_q <= retire.target;
        end
    end

    assign flush           = (state == st_flush);
    assign dispatch_hold   = (state != st_run);
    assign redirect        = (state == st_resume);
    assign redirect_target = target_q;

endmodule

// ==== rob.sv ====
/*
 * reorder buffer: circular entry store with dispatch, cdb write-back,
 * in-order retire, source operand resolution and flush
 */
`include "ooo_core_config.svh"

module rob
    import isa_pkg::*, rob_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             dispatch_valid,
    input  dispatch_t        dispatch,
    input  map_entry_t       src_map,
    input  logic [`XLEN-1:0] src_reg_value,
    input  cdb_t             cdb,
    input  logic             flush,
    output logic             rob_full,
    output rob_tag_t         tail_tag,
    output operand_t         operand,
    output retire_t          retire
);

    rob_entry_t               entries [`ROB_SZ];
    rob_tag_t                 head;
    rob_tag_t                 tail;
    // occupancy, one bit wider than a tag to tell full from empty
    logic [$clog2(`ROB_SZ):0] count;
    rob_entry_t               new_entry;

    function automatic rob_tag_t next_ptr(input rob_tag_t ptr);
        return (ptr == rob_tag_t'(`ROB_SZ - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign rob_full = (count == `ROB_SZ);
    assign tail_tag = tail;

    ////////////////////
    // dispatch
    ////////////////////

    // entry written at the tail
    always_comb begin
        new_entry        = '0;
        new_entry.valid  = 1'b1;
        new_entry.opcode = dispatch.opcode;
        if (dispatch.opcode == op_alu) begin
            new_entry.dest = dispatch.instr.alu.dest;
        end else begin
            new_entry.target = dispatch.instr.branch.target;
        end
    end

    // operand lookup order: regfile, finished entry, same-cycle cdb
    always_comb begin
        operand.tag = src_map.tag;
        if (!src_map.busy) begin
            operand.ready = 1'b1;
            operand.value = src_reg_value;
        end else if (entries[src_map.tag].complete) begin
            operand.ready = 1'b1;
            operand.value = entries[src_map.tag].value;
        end else if (cdb.valid && cdb.tag == src_map.tag) begin
            operand.ready = 1'b1;
            operand.value = cdb.value;
        end else begin
            // producer still in flight
            operand.ready = 1'b0;
            operand.value = '0;
        end
    end

    ////////////////////
    // retire
    ////////////////////

    // no retire while the flush wipes younger work
    always_comb begin
        retire.valid      = entries[head].valid && entries[head].complete && !flush;
        retire.opcode     = entries[head].opcode;
        retire.dest       = entries[head].dest;
        retire.tag        = head;
        retire.value      = entries[head].value;
        retire.mispredict = entries[head].mispredict;
        retire.target     = entries[head].target;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `ROB_SZ; i++) begin
                entries[i] <= '0;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // drop everything in flight
            for (int i = 0; i < `ROB_SZ; i++) begin
                entries[i].valid    <= 1'b0;
                entries[i].complete <= 1'b0;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (retire.valid) begin
                entries[head].valid    <= 1'b0;
                entries[head].complete <= 1'b0;
                head                   <= next_ptr(head);
            end
            // write-back from the cdb
            if (cdb.valid) begin
                entries[cdb.tag].complete   <= 1'b1;
                entries[cdb.tag].value      <= cdb.value;
                entries[cdb.tag].mispredict <= cdb.mispredict;
            end
            if (dispatch_valid) begin
                entries[tail] <= new_entry;
                tail          <= next_ptr(tail);
            end
            case ({dispatch_valid, retire.valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rob_pkg.sv ====
/*
 * back end types: rob tag and entry, dispatch, operand, cdb,
 * map entry and retire structs
 */
`include "ooo_core_config.svh"

package rob_pkg;
    import isa_pkg::*;

    typedef logic [$clog2(`ROB_SZ)-1:0] rob_tag_t;

    // decoded instruction at the core input
    typedef struct packed {
        opcode_t opcode;
        instr_u  instr;
    } dispatch_t;

    // source operand as resolved at dispatch
    typedef struct packed {
        logic             ready;
        logic [`XLEN-1:0] value;
        // producer to wait for when not ready
        rob_tag_t         tag;
    } operand_t;

    // one result per cycle
    typedef struct packed {
        logic             valid;
        rob_tag_t         tag;
        logic [`XLEN-1:0] value;
        logic             mispredict;
    } cdb_t;

    typedef struct packed {
        logic             valid;
        logic             complete;
        logic             mispredict;
        opcode_t          opcode;
        reg_idx_t         dest;
        logic [`XLEN-1:0] value;
        logic [`XLEN-1:0] target;
    } rob_entry_t;

    // rename state per architectural register
    typedef struct packed {
        logic     busy;
        rob_tag_t tag;
    } map_entry_t;

    // head of the rob, in program order
    typedef struct packed {
        logic             valid;
        opcode_t          opcode;
        reg_idx_t         dest;
        // tag lets the map table spot a stale rename
        rob_tag_t         tag;
        logic [`XLEN-1:0] value;
        logic             mispredict;
        logic [`XLEN-1:0] target;
    } retire_t;

endpackage
